// ==== verilog.f ====
pcie_shim_pkg.sv
stream_fifo.sv
write_commit_gen.sv
rxreq_arb_mux.sv
tag_mode_capture.sv
pcie_shim_csr.sv
pcie_shim_top.sv
pcie_shim_assert.sv
tb_pcie_shim.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the shim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_pcie_shim \
   -f verilog.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "Simulation finished: PASS" sim.log

// ==== tb_pcie_shim.sv ====
/*
 * Testbench for the host interface shim
 * Table-driven TX and host traffic under random back-pressure,
 * then shadow tag mode and Wishbone register checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_pcie_shim;

   localparam logic [7:0] WR = pcie_shim_pkg::TYPE_MEM_WR;
   localparam logic [7:0] RD = pcie_shim_pkg::TYPE_MEM_RD;

   //------------------------------------------------------------
   // Stimulus table
   //------------------------------------------------------------
   localparam int N_TX = 12;
   localparam logic [7:0] TX_TYPE  [N_TX] = '{WR, WR, WR, WR, WR, WR, RD, WR, WR, RD, WR, WR};
   localparam logic [7:0] TX_TAG   [N_TX] = '{8'h10, 8'h11, 8'h12, 8'h13, 8'h14, 8'h15,
                                              8'h16, 8'h17, 8'h18, 8'h19, 8'h1A, 8'h1B};
   localparam int         TX_BEATS [N_TX] = '{1, 1, 1, 2, 1, 1, 3, 1, 1, 2, 4, 1};
   localparam int N_HOST = 6;
   localparam logic [7:0] HOST_TAG   [N_HOST] = '{8'h80, 8'h81, 8'h82, 8'h83, 8'h84, 8'h85};
   localparam int         HOST_BEATS [N_HOST] = '{2, 1, 3, 1, 4, 2};

   logic        fim_clk = 1'b0;
   logic        rst;
   logic        tx_in_valid, tx_in_ready, tx_in_last;
   logic [63:0] tx_in_data;
   logic        tx_out_valid, tx_out_ready, tx_out_last;
   logic [63:0] tx_out_data;
   logic        rxreq_in_valid, rxreq_in_ready, rxreq_in_last;
   logic [63:0] rxreq_in_data;
   logic        rxreq_out_valid, rxreq_out_ready, rxreq_out_last;
   logic [63:0] rxreq_out_data;
   logic        shadow_valid;
   logic [39:0] shadow_data;
   pcie_shim_pkg::tag_mode_t tag_mode;
   logic        link_up;
   logic [31:0] rx_err_code;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   logic [2:0]  wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;

   logic [64:0]         exp_tx[$];       // {last, data}
   logic [64:0]         exp_host[$];
   pcie_shim_pkg::tag_t exp_commit[$];
   int                  seed = 1;
   int                  mode = 0;        // 0 random, 1 rx stall, 2 tx stall
   int                  cycles = 0;
   int                  limit;
   int                  n_writes;
   bit                  in_host = 1'b0;

   always #4 fim_clk = ~fim_clk;

   pcie_shim_top pcie_shim_top_inst (.*);

   task automatic check(input string name, input logic [64:0] got, input logic [64:0] exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   // Header carries type and tag and payload beats carry a recognizable pattern
   function automatic logic [63:0] make_beat(input logic [7:0] src, input logic [7:0] typ,
                                             input logic [7:0] tag, input int pkt, input int b);
      if (b == 0)
         return {src, 8'(pkt), 24'hC0DE00, tag, 8'h00, typ};
      return {src, 8'(pkt), 16'(b), 32'hD0D0_0000 ^ 32'(pkt * 256 + b)};
   endfunction

   function automatic logic [64:0] commit_beat(input logic [7:0] tag);
      logic [63:0] d;
      d = '0;
      d[7:0]   = pcie_shim_pkg::TYPE_CPL_COMMIT;
      d[23:16] = tag;
      return {1'b1, d};
   endfunction

   task automatic send_tx();
      logic [63:0] d;
      logic        last;
      for (int p = 0; p < N_TX; p++)
         for (int b = 0; b < TX_BEATS[p]; b++)
         begin
            d    = make_beat(8'hA1, TX_TYPE[p], TX_TAG[p], p, b);
            last = (b == TX_BEATS[p] - 1);
            tx_in_valid <= 1'b1;
            tx_in_data  <= d;
            tx_in_last  <= last;
            exp_tx.push_back({last, d});
            if (last && TX_TYPE[p] == WR)
               exp_commit.push_back(TX_TAG[p]);
            do @(posedge fim_clk); while (!tx_in_ready);
         end
      tx_in_valid <= 1'b0;
   endtask

   task automatic send_host();
      logic [63:0] d;
      logic        last;
      for (int p = 0; p < N_HOST; p++)
         for (int b = 0; b < HOST_BEATS[p]; b++)
         begin
            d    = make_beat(8'hB2, RD, HOST_TAG[p], p, b);
            last = (b == HOST_BEATS[p] - 1);
            rxreq_in_valid <= 1'b1;
            rxreq_in_data  <= d;
            rxreq_in_last  <= last;
            exp_host.push_back({last, d});
            do @(posedge fim_clk); while (!rxreq_in_ready);
         end
      rxreq_in_valid <= 1'b0;
   endtask

   task automatic wb_xfer(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      do @(posedge fim_clk); while (!wb_ack);
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   // Send a shadow message and check the mode one cycle after capture
   task automatic send_shadow(input logic [7:0] func, input logic t8, input logic t10,
                              inout pcie_shim_pkg::tag_mode_t model);
      int rnd;
      rnd = $random(seed);
      shadow_valid <= 1'b1;
      shadow_data  <= {8'(rnd), 14'd0, t10, t8, 8'h00, func};
      if (func == 8'h00)
         model = t10 ? pcie_shim_pkg::TAG_10BIT :
                 t8  ? pcie_shim_pkg::TAG_8BIT  : pcie_shim_pkg::TAG_5BIT;
      @(posedge fim_clk);
      shadow_valid <= 1'b0;
      @(posedge fim_clk);
      check("tag_mode", 65'(tag_mode), 65'(model));
   endtask

   //------------------------------------------------------------
   // Back-pressure and monitors
   //------------------------------------------------------------
   always @(posedge fim_clk)
   begin : ready_gen
      int rnd;
      rnd = $random(seed);
      case (mode)
         2:
         begin
            tx_out_ready    <= 1'b0;
            rxreq_out_ready <= rnd[1];
         end
         1:
         begin
            tx_out_ready    <= 1'b1;
            rxreq_out_ready <= 1'b0;
         end
         default:
         begin
            tx_out_ready    <= rnd[0];
            rxreq_out_ready <= rnd[1];
         end
      endcase
   end

   always @(posedge fim_clk)
   begin
      cycles <= cycles + 1;
      if (cycles > limit)
         stop_run("Timeout: the DUT stopped making progress");
   end

   always @(posedge fim_clk)
      if (!rst && tx_out_valid && tx_out_ready)
      begin
         if (exp_tx.size() == 0)
            stop_run("Unexpected beat on tx_out");
         else
            check("tx_out", {tx_out_last, tx_out_data}, exp_tx.pop_front());
      end

   always @(posedge fim_clk)
      if (!rst && rxreq_out_valid && rxreq_out_ready)
      begin
         if (!in_host && rxreq_out_data[7:0] == pcie_shim_pkg::TYPE_CPL_COMMIT)
         begin
            if (exp_commit.size() == 0)
               stop_run("Commit beat seen with no write pending");
            else
               check("rxreq_out commit", {rxreq_out_last, rxreq_out_data},
                     commit_beat(exp_commit.pop_front()));
         end
         else
         begin
            if (exp_host.size() == 0)
               stop_run("Unexpected host beat on rxreq_out");
            else
            begin
               check("rxreq_out host", {rxreq_out_last, rxreq_out_data},
                     exp_host.pop_front());
               in_host = !rxreq_out_last;
            end
         end
      end

   //------------------------------------------------------------
   // Main sequence
   //------------------------------------------------------------
   initial
   begin : main
      pcie_shim_pkg::tag_mode_t model;
      logic [31:0]              rd;
      int                       beats;
      rst = 1'b1;
      tx_in_valid = 1'b0;
      tx_in_data = '0;
      tx_in_last = 1'b0;
      rxreq_in_valid = 1'b0;
      rxreq_in_data = '0;
      rxreq_in_last = 1'b0;
      tx_out_ready = 1'b0;
      rxreq_out_ready = 1'b0;
      shadow_valid = 1'b0;
      shadow_data = '0;
      link_up = 1'b0;
      rx_err_code = '0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      beats = 0;
      n_writes = 0;
      for (int p = 0; p < N_TX; p++)
      begin
         beats += TX_BEATS[p] + 1;
         if (TX_TYPE[p] == WR)
            n_writes++;
      end
      for (int p = 0; p < N_HOST; p++)
         beats += HOST_BEATS[p];
      limit = beats * 40 + 1000;           // Stall margin plus register phase

      repeat (5) @(posedge fim_clk);
      rst <= 1'b0;
      @(posedge fim_clk);
      model = pcie_shim_pkg::TAG_5BIT;
      check("tag_mode", 65'(tag_mode), 65'(model));

      fork
         send_tx();
         send_host();
         begin
            mode <= 2;                    // Fill the TX buffer
            repeat (30) @(posedge fim_clk);
            mode <= 1;                    // Writes flow while commits pile up
            repeat (40) @(posedge fim_clk);
            mode <= 0;
         end
      join
      while (exp_tx.size() != 0 || exp_host.size() != 0 || exp_commit.size() != 0)
         @(posedge fim_clk);

      send_shadow(8'h00, 1'b1, 1'b0, model);
      send_shadow(8'h03, 1'b0, 1'b1, model);   // Other function is ignored
      send_shadow(8'h00, 1'b1, 1'b1, model);
      send_shadow(8'h00, 1'b0, 1'b0, model);
      send_shadow(8'h00, 1'b0, 1'b1, model);

      link_up     <= 1'b1;
      rx_err_code <= 32'h0BAD_F00D;
      wb_xfer(1'b0, pcie_shim_pkg::REG_FEATURE, '0, rd);
      check("REG_FEATURE", 65'(rd), 65'(pcie_shim_pkg::FEAT_ID));
      wb_xfer(1'b1, pcie_shim_pkg::REG_SCRATCH, 32'hC0FF_EE11, rd);
      wb_xfer(1'b0, pcie_shim_pkg::REG_SCRATCH, '0, rd);
      check("REG_SCRATCH", 65'(rd), 65'(32'hC0FF_EE11));
      wb_xfer(1'b0, pcie_shim_pkg::REG_STATUS, '0, rd);
      check("REG_STATUS", 65'(rd), 65'({26'd0, model, 4'b0001}));
      wb_xfer(1'b0, pcie_shim_pkg::REG_RX_ERR, '0, rd);
      check("REG_RX_ERR", 65'(rd), 65'(32'h0BAD_F00D));
      wb_xfer(1'b0, pcie_shim_pkg::REG_COMMIT_CNT, '0, rd);
      check("REG_COMMIT_CNT", 65'(rd), 65'(n_writes));
      wb_xfer(1'b1, pcie_shim_pkg::REG_FEATURE, 32'hFFFF_FFFF, rd);
      wb_xfer(1'b0, pcie_shim_pkg::REG_FEATURE, '0, rd);
      check("REG_FEATURE", 65'(rd), 65'(pcie_shim_pkg::FEAT_ID));
      wb_xfer(1'b0, 3'd7, '0, rd);
      check("unmapped register", 65'(rd), 65'd0);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== pcie_shim_assert.sv ====
/*
 * Stream and Wishbone protocol assertions bound into the shim top level
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_shim_assert (
   input wire        fim_clk,
   input wire        rst,
   input wire        tx_out_valid,
   input wire        tx_out_ready,
   input wire [63:0] tx_out_data,
   input wire        tx_out_last,
   input wire        rxreq_out_valid,
   input wire        rxreq_out_ready,
   input wire [63:0] rxreq_out_data,
   input wire        rxreq_out_last,
   input wire        wb_stb,
   input wire        wb_ack
);

   // Stalled beats must not change
   tx_hold_a : assert property (@(posedge fim_clk) disable iff (rst)
      tx_out_valid && !tx_out_ready |=>
         tx_out_valid && $stable(tx_out_data) && $stable(tx_out_last))
      else $error("tx_out changed while stalled");

   rx_hold_a : assert property (@(posedge fim_clk) disable iff (rst)
      rxreq_out_valid && !rxreq_out_ready |=>
         rxreq_out_valid && $stable(rxreq_out_data) && $stable(rxreq_out_last))
      else $error("rxreq_out changed while stalled");

   ack_stb_a : assert property (@(posedge fim_clk) disable iff (rst) wb_ack |-> wb_stb)
      else $error("wb_ack without wb_stb");

   ack_pulse_a : assert property (@(posedge fim_clk) disable iff (rst) wb_ack |=> !wb_ack)
      else $error("wb_ack high for two cycles");

endmodule

bind pcie_shim_top pcie_shim_assert pcie_shim_assert_inst (.*);

`default_nettype wire

// ==== pcie_shim_top.sv ====
/*
 * Host interface shim top level
 * TX write commits, request merge, tag mode capture and status registers
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_shim_top (
   input  logic                                fim_clk,
   input  logic                                rst,
   // Accelerator TX
   input  logic                                tx_in_valid,
   output logic                                tx_in_ready,
   input  logic [pcie_shim_pkg::DATA_W-1:0]    tx_in_data,
   input  logic                                tx_in_last,
   // TX toward the subsystem
   output logic                                tx_out_valid,
   input  logic                                tx_out_ready,
   output logic [pcie_shim_pkg::DATA_W-1:0]    tx_out_data,
   output logic                                tx_out_last,
   // Host requests
   input  logic                                rxreq_in_valid,
   output logic                                rxreq_in_ready,
   input  logic [pcie_shim_pkg::DATA_W-1:0]    rxreq_in_data,
   input  logic                                rxreq_in_last,
   // Merged requests toward the accelerator
   output logic                                rxreq_out_valid,
   input  logic                                rxreq_out_ready,
   output logic [pcie_shim_pkg::DATA_W-1:0]    rxreq_out_data,
   output logic                                rxreq_out_last,
   // Control shadow and status
   input  logic                                shadow_valid,
   input  logic [pcie_shim_pkg::SHADOW_W-1:0]  shadow_data,
   output pcie_shim_pkg::tag_mode_t            tag_mode,
   input  logic                                link_up,
   input  logic [31:0]                         rx_err_code,
   // Wishbone slave
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [pcie_shim_pkg::WB_ADR_W-1:0]  wb_adr,
   input  logic [pcie_shim_pkg::WB_DATA_W-1:0] wb_dat_w,
   output logic [pcie_shim_pkg::WB_DATA_W-1:0] wb_dat_r,
   output logic                                wb_ack
);

   logic                             commit_valid;
   logic                             commit_ready;
   logic [pcie_shim_pkg::DATA_W-1:0] commit_data;
   logic                             commit_last;
   logic                             commit_sent;

   write_commit_gen write_commit_gen_inst (
      .fim_clk      (fim_clk),
      .rst          (rst),
      .tx_in_valid  (tx_in_valid),
      .tx_in_ready  (tx_in_ready),
      .tx_in_data   (tx_in_data),
      .tx_in_last   (tx_in_last),
      .tx_out_valid (tx_out_valid),
      .tx_out_ready (tx_out_ready),
      .tx_out_data  (tx_out_data),
      .tx_out_last  (tx_out_last),
      .commit_valid (commit_valid),
      .commit_ready (commit_ready),
      .commit_data  (commit_data),
      .commit_last  (commit_last)
   );

   rxreq_arb_mux rxreq_arb_mux_inst (
      .fim_clk      (fim_clk),
      .rst          (rst),
      .host_valid   (rxreq_in_valid),
      .host_ready   (rxreq_in_ready),
      .host_data    (rxreq_in_data),
      .host_last    (rxreq_in_last),
      .commit_valid (commit_valid),
      .commit_ready (commit_ready),
      .commit_data  (commit_data),
      .commit_last  (commit_last),
      .out_valid    (rxreq_out_valid),
      .out_ready    (rxreq_out_ready),
      .out_data     (rxreq_out_data),
      .out_last     (rxreq_out_last),
      .commit_sent  (commit_sent)
   );

   tag_mode_capture tag_mode_capture_inst (
      .fim_clk      (fim_clk),
      .rst          (rst),
      .shadow_valid (shadow_valid),
      .shadow_data  (shadow_data),
      .tag_mode     (tag_mode)
   );

   pcie_shim_csr pcie_shim_csr_inst (
      .fim_clk      (fim_clk),
      .rst          (rst),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .link_up      (link_up),
      .rx_err_code  (rx_err_code),
      .tag_mode     (tag_mode),
      .commit_sent  (commit_sent)
   );

endmodule

`default_nettype wire

// ==== pcie_shim_csr.sv ====
/*
 * Shim status registers on Wishbone classic
 * Feature ID, link status, RX error code, commit count and scratch
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_shim_csr (
   input  logic                                fim_clk,
   input  logic                                rst,
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [pcie_shim_pkg::WB_ADR_W-1:0]  wb_adr,
   input  logic [pcie_shim_pkg::WB_DATA_W-1:0] wb_dat_w,
   output logic [pcie_shim_pkg::WB_DATA_W-1:0] wb_dat_r,
   output logic                                wb_ack,
   input  logic                                link_up,
   input  logic [31:0]                         rx_err_code,
   input  pcie_shim_pkg::tag_mode_t            tag_mode,
   input  logic                                commit_sent
);

   logic                                req;
   logic [pcie_shim_pkg::WB_DATA_W-1:0] scratch;
   logic [pcie_shim_pkg::WB_DATA_W-1:0] commit_cnt;
   logic [pcie_shim_pkg::WB_DATA_W-1:0] rd_data;

   assign req = wb_cyc && wb_stb && !wb_ack;   // New cycle not yet acked

   //------------------------------------------------------------
   // Read mux
   //------------------------------------------------------------
   always_comb
   begin
      case (wb_adr)
         pcie_shim_pkg::REG_FEATURE:    rd_data = pcie_shim_pkg::FEAT_ID;
         pcie_shim_pkg::REG_STATUS:     rd_data = {26'd0, tag_mode, 3'd0, link_up};
         pcie_shim_pkg::REG_RX_ERR:     rd_data = rx_err_code;
         pcie_shim_pkg::REG_COMMIT_CNT: rd_data = commit_cnt;
         pcie_shim_pkg::REG_SCRATCH:    rd_data = scratch;
         default:                       rd_data = '0;
      endcase
   end

   always_ff @(posedge fim_clk)
   begin
      if (rst)
      begin
         wb_ack     <= 1'b0;
         scratch    <= '0;
         commit_cnt <= '0;
      end
      else
      begin
         wb_ack <= req;
         // Only scratch is writable
         if (req && wb_we && (wb_adr == pcie_shim_pkg::REG_SCRATCH))
            scratch <= wb_dat_w;
         if (commit_sent)
            commit_cnt <= commit_cnt + 1'b1;
      end
   end

   always_ff @(posedge fim_clk)
   begin
      if (req)
         wb_dat_r <= rd_data;   // Valid with ack
   end

endmodule

`default_nettype wire

// ==== tag_mode_capture.sv ====
/*
 * Tag mode capture
 * Tracks the function-0 tag mode from control-shadow messages
 */
`timescale 1ns/10ps
`default_nettype none

module tag_mode_capture (
   input  logic                               fim_clk,
   input  logic                               rst,
   input  logic                               shadow_valid,
   input  logic [pcie_shim_pkg::SHADOW_W-1:0] shadow_data,
   output pcie_shim_pkg::tag_mode_t           tag_mode
);

   logic func0;

   assign func0 = (shadow_data[pcie_shim_pkg::SHADOW_FUNC_LSB +: pcie_shim_pkg::SHADOW_FUNC_W]
                   == '0);

   always_ff @(posedge fim_clk)
   begin
      if (rst)
         tag_mode <= pcie_shim_pkg::TAG_5BIT;
      else if (shadow_valid && func0)
      begin
         // 10-bit wins over 8-bit
         if (shadow_data[pcie_shim_pkg::SHADOW_TAG10_BIT])
            tag_mode <= pcie_shim_pkg::TAG_10BIT;
         else if (shadow_data[pcie_shim_pkg::SHADOW_TAG8_BIT])
            tag_mode <= pcie_shim_pkg::TAG_8BIT;
         else
            tag_mode <= pcie_shim_pkg::TAG_5BIT;
      end
   end

endmodule

`default_nettype wire

// ==== rxreq_arb_mux.sv ====
/*
 * Two-channel request merge
 * Packet-atomic round robin between host requests and write commits
 */
`timescale 1ns/10ps
`default_nettype none

module rxreq_arb_mux (
   input  logic                             fim_clk,
   input  logic                             rst,
   input  logic                             host_valid,
   output logic                             host_ready,
   input  logic [pcie_shim_pkg::DATA_W-1:0] host_data,
   input  logic                             host_last,
   input  logic                             commit_valid,
   output logic                             commit_ready,
   input  logic [pcie_shim_pkg::DATA_W-1:0] commit_data,
   input  logic                             commit_last,
   output logic                             out_valid,
   input  logic                             out_ready,
   output logic [pcie_shim_pkg::DATA_W-1:0] out_data,
   output logic                             out_last,
   output logic                             commit_sent
);

   logic                             locked;    // Mid-packet
   logic                             grant;     // 1 = commit channel
   logic                             prio;      // Preferred channel for next packet
   logic                             sel;
   logic                             sel_valid;
   logic                             sel_last;
   logic [pcie_shim_pkg::DATA_W-1:0] sel_data;
   logic                             can_load;
   logic                             take;
   logic                             out_src;

   // Output stage can refill in the cycle it drains
   assign can_load = !out_valid || out_ready;

   always_comb
   begin
      if (locked)
         sel = grant;
      else if (prio)
         sel = commit_valid || !host_valid;
      else
         sel = commit_valid && !host_valid;
   end

   assign sel_valid = sel ? commit_valid : host_valid;
   assign sel_last  = sel ? commit_last  : host_last;
   assign sel_data  = sel ? commit_data  : host_data;
   assign take      = sel_valid && can_load;

   assign host_ready   = can_load && !sel;
   assign commit_ready = can_load && sel;
   assign commit_sent  = out_valid && out_ready && out_src;

   //------------------------------------------------------------
   // Grant tracking and output register
   //------------------------------------------------------------
   always_ff @(posedge fim_clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
         out_src   <= 1'b0;
         locked    <= 1'b0;
         grant     <= 1'b0;
         prio      <= 1'b0;
      end
      else if (take)
      begin
         out_valid <= 1'b1;
         out_src   <= sel;
         grant     <= sel;
         locked    <= !sel_last;
         if (sel_last)
            prio <= !sel;            // Other side goes first next time
      end
      else if (out_ready)
      begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge fim_clk)
   begin
      if (take)
      begin
         out_data <= sel_data;
         out_last <= sel_last;
      end
   end

endmodule

`default_nettype wire

// ==== write_commit_gen.sv ====
/*
 * Write commit generator
 * Buffers the TX stream and returns a commit beat with the tag of each
 * memory write once its last beat has been taken downstream
 */
`timescale 1ns/10ps
`default_nettype none

module write_commit_gen (
   input  logic                             fim_clk,
   input  logic                             rst,
   input  logic                             tx_in_valid,
   output logic                             tx_in_ready,
   input  logic [pcie_shim_pkg::DATA_W-1:0] tx_in_data,
   input  logic                             tx_in_last,
   output logic                             tx_out_valid,
   input  logic                             tx_out_ready,
   output logic [pcie_shim_pkg::DATA_W-1:0] tx_out_data,
   output logic                             tx_out_last,
   output logic                             commit_valid,
   input  logic                             commit_ready,
   output logic [pcie_shim_pkg::DATA_W-1:0] commit_data,
   output logic                             commit_last
);

   pcie_shim_pkg::beat_t buf_beat;
   pcie_shim_pkg::tag_t  hdr_tag;
   pcie_shim_pkg::tag_t  pkt_tag;
   pcie_shim_pkg::tag_t  cur_tag;
   pcie_shim_pkg::tag_t  cq_tag;
   logic                 buf_valid;
   logic                 hold;
   logic                 sop;
   logic                 hdr_is_wr;
   logic                 pkt_is_wr;
   logic                 cur_is_wr;
   logic                 cq_ready;
   logic                 tx_xfer;
   logic                 push;

   //------------------------------------------------------------
   // TX buffer
   //------------------------------------------------------------
   stream_fifo #(
      .payload_t (pcie_shim_pkg::beat_t),
      .DEPTH     (pcie_shim_pkg::TX_FIFO_DEPTH)
   ) tx_buf (
      .fim_clk   (fim_clk),
      .rst       (rst),
      .in_valid  (tx_in_valid),
      .in_ready  (tx_in_ready),
      .in_data   ({tx_in_last, tx_in_data}),
      .out_valid (buf_valid),
      .out_ready (tx_out_ready && !hold),
      .out_data  (buf_beat),
      .count     ()
   );

   assign hdr_is_wr = (buf_beat[pcie_shim_pkg::HDR_TYPE_LSB +: pcie_shim_pkg::HDR_TYPE_W]
                       == pcie_shim_pkg::TYPE_MEM_WR);
   assign hdr_tag   = buf_beat[pcie_shim_pkg::HDR_TAG_LSB +: pcie_shim_pkg::HDR_TAG_W];
   assign cur_is_wr = sop ? hdr_is_wr : pkt_is_wr;
   assign cur_tag   = sop ? hdr_tag : pkt_tag;

   // Keep the last beat of a write back until its commit has a slot
   assign hold = buf_beat[pcie_shim_pkg::DATA_W] && cur_is_wr && !cq_ready;

   assign tx_out_valid = buf_valid && !hold;
   assign tx_out_data  = buf_beat[pcie_shim_pkg::DATA_W-1:0];
   assign tx_out_last  = buf_beat[pcie_shim_pkg::DATA_W];
   assign tx_xfer      = tx_out_valid && tx_out_ready;
   assign push         = tx_xfer && tx_out_last && cur_is_wr;

   always_ff @(posedge fim_clk)
   begin
      if (rst)
      begin
         sop       <= 1'b1;
         pkt_is_wr <= 1'b0;
      end
      else if (tx_xfer)
      begin
         sop <= tx_out_last;          // Next beat opens a packet
         if (sop)
            pkt_is_wr <= hdr_is_wr;
      end
   end

   always_ff @(posedge fim_clk)
   begin
      if (tx_xfer && sop)
         pkt_tag <= hdr_tag;
   end

   //------------------------------------------------------------
   // Commit queue
   //------------------------------------------------------------
   stream_fifo #(
      .payload_t (pcie_shim_pkg::tag_t),
      .DEPTH     (pcie_shim_pkg::COMMIT_FIFO_DEPTH)
   ) commit_q (
      .fim_clk   (fim_clk),
      .rst       (rst),
      .in_valid  (push),
      .in_ready  (cq_ready),
      .in_data   (cur_tag),
      .out_valid (commit_valid),
      .out_ready (commit_ready),
      .out_data  (cq_tag),
      .count     ()
   );

   // One-beat completion with only type and tag set
   always_comb
   begin
      commit_data = '0;
      commit_data[pcie_shim_pkg::HDR_TYPE_LSB +: pcie_shim_pkg::HDR_TYPE_W] =
         pcie_shim_pkg::TYPE_CPL_COMMIT;
      commit_data[pcie_shim_pkg::HDR_TAG_LSB +: pcie_shim_pkg::HDR_TAG_W] = cq_tag;
   end

   assign commit_last = 1'b1;

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
/*
 * Small valid/ready FIFO
 * Circular buffer with a generic payload type, head read from storage flops
 */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 2
)(
   input  logic                       fim_clk,
   input  logic                       rst,
   input  logic                       in_valid,
   output logic                       in_ready,
   input  payload_t                   in_data,
   output logic                       out_valid,
   input  logic                       out_ready,
   output payload_t                   out_data,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH+1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      next_ptr = (p == PTR_W'(DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));   // Not full
   assign out_valid = (count != '0);
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;
   assign out_data  = mem[rd_ptr];

   always_ff @(posedge fim_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge fim_clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

endmodule

`default_nettype wire

// ==== pcie_shim_pkg.sv ====
/*
 * Host interface shim shared definitions
 * Stream widths, header fields, type codes, tag modes and register map
 */
`default_nettype none

package pcie_shim_pkg;

   //------------------------------------------------------------
   // Streams
   //------------------------------------------------------------
   localparam int DATA_W        = 64;

   localparam int HDR_TYPE_LSB  = 0;
   localparam int HDR_TYPE_W    = 8;
   localparam int HDR_TAG_LSB   = 16;
   localparam int HDR_TAG_W     = 8;

   localparam logic [HDR_TYPE_W-1:0] TYPE_MEM_WR     = 8'h60;
   localparam logic [HDR_TYPE_W-1:0] TYPE_MEM_RD     = 8'h20;
   localparam logic [HDR_TYPE_W-1:0] TYPE_CPL_COMMIT = 8'h0A;   // Cpl without data

   typedef logic [DATA_W:0]      beat_t;   // {last, data}
   typedef logic [HDR_TAG_W-1:0] tag_t;

   localparam int TX_FIFO_DEPTH     = 2;
   localparam int COMMIT_FIFO_DEPTH = 4;

   //------------------------------------------------------------
   // Control shadow
   //------------------------------------------------------------
   localparam int SHADOW_W         = 40;
   localparam int SHADOW_FUNC_LSB  = 0;
   localparam int SHADOW_FUNC_W    = 8;
   localparam int SHADOW_TAG8_BIT  = 16;
   localparam int SHADOW_TAG10_BIT = 17;

   typedef enum logic [1:0] {
      TAG_5BIT  = 2'd0,
      TAG_8BIT  = 2'd1,
      TAG_10BIT = 2'd2
   } tag_mode_t;

   //------------------------------------------------------------
   // Register block
   //------------------------------------------------------------
   localparam int WB_ADR_W  = 3;
   localparam int WB_DATA_W = 32;

   localparam logic [WB_ADR_W-1:0] REG_FEATURE    = 3'd0;
   localparam logic [WB_ADR_W-1:0] REG_STATUS     = 3'd1;
   localparam logic [WB_ADR_W-1:0] REG_RX_ERR     = 3'd2;
   localparam logic [WB_ADR_W-1:0] REG_COMMIT_CNT = 3'd3;
   localparam logic [WB_ADR_W-1:0] REG_SCRATCH    = 3'd4;

   localparam logic [WB_DATA_W-1:0] FEAT_ID = 32'h0000_1020;

endpackage

`default_nettype wire
